//--- build.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_burst_unit.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

//--- dv/dcache_mem_model.sv
`include "dcache_macros.svh"

module dcache_mem_model (
    input  logic                  clk,
    input  dcache_pkg::axi_addr_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output dcache_pkg::word_t     r_data,
    output logic                  r_last,
    output logic                  r_valid,
    input  logic                  r_ready,
    input  dcache_pkg::axi_addr_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  dcache_pkg::word_t     w_data,
    input  logic                  w_last,
    input  logic                  w_valid,
    output logic                  w_ready,
    output logic                  b_valid
);
    import dcache_pkg::*;

    localparam int HOLD_LIMIT = 2000;

    logic [7:0] mem_bytes [addr_t];

    // untouched bytes hash their full address
    function automatic logic [7:0] init_byte(addr_t a);
        logic [31:0] h;
        h = (a ^ 32'h5bd1_e995) * 32'h9e37_79b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [7:0] peek_byte(addr_t a);
        if (mem_bytes.exists(a)) begin
            return mem_bytes[a];
        end
        return init_byte(a);
    endfunction

    function automatic word_t peek_word(addr_t a);
        return {peek_byte(a + 3), peek_byte(a + 2), peek_byte(a + 1), peek_byte(a)};
    endfunction

    task automatic ready_delay();
        repeat ($urandom_range(0, 3)) @(negedge clk);
    endtask

    initial begin : read_side
        axi_addr_t rd_req;
        int        hold;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        r_data   = '0;
        forever begin
            @(negedge clk);
            if (ar_valid) begin
                ready_delay();
                ar_ready = 1'b1;
                rd_req   = ar;
                @(negedge clk);
                ar_ready = 1'b0;
                for (int i = 0; i < `DC_WORDS; i++) begin
                    ready_delay();
                    r_valid = 1'b1;
                    r_data  = peek_word(rd_req.addr + 4 * i);
                    r_last  = (i == `DC_WORDS - 1);
                    // beat stays up until the cache takes it
                    hold = 0;
                    do begin
                        @(posedge clk);
                        hold++;
                    end while (!r_ready && hold < HOLD_LIMIT);
                    @(negedge clk);
                    r_valid = 1'b0;
                    r_last  = 1'b0;
                end
            end
        end
    end

    initial begin : write_side
        axi_addr_t wr_req;
        int        hold;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(negedge clk);
            if (aw_valid) begin
                ready_delay();
                aw_ready = 1'b1;
                wr_req   = aw;
                @(negedge clk);
                aw_ready = 1'b0;
                for (int i = 0; i < `DC_WORDS; i++) begin
                    ready_delay();
                    w_ready = 1'b1;
                    hold    = 0;
                    do begin
                        @(posedge clk);
                        hold++;
                    end while (!w_valid && hold < HOLD_LIMIT);
                    for (int b = 0; b < 4; b++) begin
                        mem_bytes[wr_req.addr + 4 * i + b] = w_data[8*b +: 8];
                    end
                    @(negedge clk);
                    w_ready = 1'b0;
                end
                ready_delay();
                b_valid = 1'b1;
                @(negedge clk);
                b_valid = 1'b0;
            end
        end
    end

endmodule

//--- dv/dcache_tb.sv
`include "dcache_macros.svh"

module dcache_tb;
    import dcache_pkg::*;

    logic      clk;
    logic      rst;
    logic      req;
    cpu_req_t  cpu_req;
    logic      done;
    word_t     rdata;
    axi_addr_t ar;
    axi_addr_t aw;
    logic      ar_valid;
    logic      ar_ready;
    logic      r_last;
    logic      r_valid;
    logic      r_ready;
    logic      aw_valid;
    logic      aw_ready;
    logic      w_last;
    logic      w_valid;
    logic      w_ready;
    logic      b_valid;
    word_t     r_data;
    word_t     w_data;

    logic [7:0] shadow [addr_t];
    int         ar_count;
    int         aw_count;
    int         w_beats;
    addr_t      last_ar;
    addr_t      wb_addr;
    logic       burst_seen;
    logic       r_open;
    logic       w_open;

    dcache_top dut (.*);

    dcache_mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_note(string what);
        $display("t=%0t error: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [7:0] shadow_byte(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return mem.init_byte(a);
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return {shadow_byte(a + 3), shadow_byte(a + 2), shadow_byte(a + 1), shadow_byte(a)};
    endfunction

    task automatic store_shadow(addr_t a, word_t d, strb_t s);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[a + b] = d[8*b +: 8];
            end
        end
    endtask

    // protocol monitor on the memory side
    always @(posedge clk) begin
        if (!rst) begin
            if (ar_valid || aw_valid) begin
                burst_seen = 1'b1;
            end
            // bursts never overlap and a refill waits for the write response
            if (ar_valid) begin
                assert (!r_open && !w_open)
                    else fail_note("ar_valid raised while another burst is open");
            end
            if (aw_valid) begin
                assert (!r_open && !w_open)
                    else fail_note("aw_valid raised while another burst is open");
            end
            if (r_ready) begin
                assert (r_open) else fail_note("r_ready high outside a read burst");
            end
            if (w_valid) begin
                assert (w_open) else fail_note("w_valid high outside a write burst");
            end
            if (ar_valid && ar_ready) begin
                assert (ar.len == 8'd7) else fail_value("ar.len", ar.len, 7);
                assert (ar.addr[4:0] == 0) else fail_value("ar.addr[4:0]", ar.addr[4:0], 0);
                last_ar = ar.addr;
                ar_count++;
                r_open = 1'b1;
            end
            if (r_valid && r_ready && r_last) begin
                r_open = 1'b0;
            end
            if (aw_valid && aw_ready) begin
                assert (aw.len == 8'd7) else fail_value("aw.len", aw.len, 7);
                assert (aw.addr[4:0] == 0) else fail_value("aw.addr[4:0]", aw.addr[4:0], 0);
                assert (w_beats == 0) else fail_value("w beats at aw", w_beats, 0);
                wb_addr = aw.addr;
                aw_count++;
                w_open = 1'b1;
            end
            if (w_valid && w_ready) begin
                assert (w_last == (w_beats == 7)) else fail_value("w_last", w_last, w_beats == 7);
                w_beats = w_last ? 0 : w_beats + 1;
            end
            if (b_valid) begin
                assert (w_beats == 0) else fail_value("w beats at b_valid", w_beats, 0);
                // written-back line in memory must match what the core saw
                for (int i = 0; i < `DC_WORDS; i++) begin
                    assert (mem.peek_word(wb_addr + 4 * i) == shadow_word(wb_addr + 4 * i))
                        else fail_value("mem line word", mem.peek_word(wb_addr + 4 * i),
                                        shadow_word(wb_addr + 4 * i));
                end
                w_open = 1'b0;
            end
        end
    end

    // starts on a falling edge and returns on the falling edge of the done cycle
    task automatic access(input addr_t a, input logic we, input word_t wd, input strb_t ws,
                          output word_t rd, output int cycles);
        @(negedge clk);
        cpu_req = '{addr: a, wdata: wd, wstrb: ws, we: we};
        req     = 1'b1;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < 2000);
        if (!done) begin
            fail_note("timeout waiting for done from the cache");
        end
        rd  = rdata;
        req = 1'b0;
    endtask

    task automatic checked_access(input addr_t a, input logic we, input word_t wd,
                                  input strb_t ws, output int cycles);
        word_t rd;
        word_t exp;
        exp = shadow_word(a);
        access(a, we, wd, ws, rd, cycles);
        if (we) begin
            store_shadow(a, wd, ws);
        end else begin
            assert (rd == exp) else fail_value("rdata", rd, exp);
        end
    endtask

    task automatic check_hit(input addr_t a, input logic we, input word_t wd, input strb_t ws);
        int cycles;
        burst_seen = 1'b0;
        checked_access(a, we, wd, ws, cycles);
        assert (cycles == 2) else fail_value("done latency", cycles, 2);
        assert (!burst_seen) else fail_value("ar_valid|aw_valid", burst_seen, 0);
    endtask

    task automatic line_sequence();
        addr_t a_line;
        addr_t b_line;
        addr_t c_line;
        addr_t e_line;
        int    cycles;
        int    aw0;
        int    ar0;
        a_line = {20'h00a11, 7'h15, 5'd0};
        b_line = {20'h00b22, 7'h15, 5'd0};
        c_line = {20'h00c33, 7'h15, 5'd0};
        e_line = {20'h00e55, 7'h15, 5'd0};
        checked_access(a_line + 8, 1'b1, $urandom, 4'hf, cycles);
        checked_access(b_line + 12, 1'b1, $urandom, 4'h5, cycles);
        check_hit(a_line + 8, 1'b0, '0, '0);
        aw0 = aw_count;
        ar0 = ar_count;
        checked_access(c_line + 4, 1'b0, '0, '0, cycles);
        assert (aw_count == aw0 + 1) else fail_value("aw bursts for C", aw_count - aw0, 1);
        assert (wb_addr == b_line) else fail_value("aw.addr", wb_addr, b_line);
        assert (ar_count == ar0 + 1) else fail_value("ar bursts for C", ar_count - ar0, 1);
        assert (last_ar == c_line) else fail_value("ar.addr", last_ar, c_line);
        check_hit(a_line + 8, 1'b0, '0, '0);
        // C is clean and now the victim
        aw0 = aw_count;
        checked_access(e_line, 1'b0, '0, '0, cycles);
        assert (aw_count == aw0) else fail_value("aw bursts on clean eviction", aw_count - aw0, 0);
        assert (last_ar == e_line) else fail_value("ar.addr", last_ar, e_line);
    endtask

    initial begin
        tag_t  tag_pool [4];
        addr_t a;
        int    cycles;
        int    pick_tag;
        int    pick_set;
        void'($urandom(32'hc507));
        rst        = 1'b1;
        req        = 1'b0;
        cpu_req    = '0;
        ar_count   = 0;
        aw_count   = 0;
        w_beats    = 0;
        burst_seen = 1'b0;
        r_open     = 1'b0;
        w_open     = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!done) else fail_value("done", done, 0);
        assert (!ar_valid) else fail_value("ar_valid", ar_valid, 0);
        assert (!aw_valid) else fail_value("aw_valid", aw_valid, 0);
        assert (!w_valid) else fail_value("w_valid", w_valid, 0);
        assert (!r_ready) else fail_value("r_ready", r_ready, 0);

        // first load sees the memory's initial content
        a = $urandom;
        a = {a[31:12], 7'h01, a[4:2], 2'b00};
        checked_access(a, 1'b0, '0, '0, cycles);
        check_hit(a ^ 32'h4, 1'b0, '0, '0);

        line_sequence();

        // random traffic on a few sets with more tags than ways
        for (int i = 0; i < 4; i++) begin
            tag_pool[i] = tag_t'($urandom);
        end
        for (int n = 0; n < 80; n++) begin
            pick_tag = $urandom_range(0, 3);
            pick_set = $urandom_range(0, 3);
            a = {tag_pool[pick_tag], 7'h20 + 7'(pick_set), 5'd0};
            a = a | ($urandom & 32'h1c);
            checked_access(a, $urandom_range(0, 1), $urandom, $urandom, cycles);
            a = (a & ~32'h1f) | ($urandom & 32'h1c);
            check_hit(a, $urandom_range(0, 1), $urandom, $urandom);
        end

        repeat (4) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- hdl/dcache_burst_unit.sv
`include "dcache_macros.svh"

module dcache_burst_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  dcache_pkg::burst_cmd_t cmd,
    input  dcache_pkg::addr_t      fill_addr,
    output logic                   cmd_done,
    output dcache_pkg::index_t     line_index,
    output dcache_pkg::way_t       line_way,
    output dcache_pkg::word_sel_t  line_word,
    input  dcache_pkg::word_t      line_data,
    output dcache_pkg::fill_beat_t fill_wr,
    output logic                   fill_wr_en,
    output dcache_pkg::axi_addr_t  ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  dcache_pkg::word_t      r_data,
    input  logic                   r_last,
    input  logic                   r_valid,
    output logic                   r_ready,
    output dcache_pkg::axi_addr_t  aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output dcache_pkg::word_t      w_data,
    output logic                   w_last,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   b_valid
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        BU_IDLE,
        BU_BUFFER,
        BU_AW,
        BU_W,
        BU_B,
        BU_AR,
        BU_R
    } bu_state_e;

    localparam logic [7:0] BURST_LEN = 8'(`DC_BURST_LEN);

    bu_state_e                  state;
    burst_cmd_t                 cmd_q;
    logic [$clog2(`DC_WORDS):0] cnt;
    word_sel_t                  beat;
    word_t                      line_buf [`DC_WORDS];

    assign beat = word_sel_t'(cnt);

    // victim line read, one word per cycle
    assign line_index = addr_index(cmd_q.addr);
    assign line_way   = cmd_q.way;
    assign line_word  = beat;

    assign aw       = '{addr: cmd_q.addr, len: BURST_LEN};
    assign aw_valid = state == BU_AW;
    assign w_valid  = state == BU_W;
    assign w_data   = line_buf[beat];
    assign w_last   = beat == word_sel_t'(`DC_BURST_LEN);

    assign ar       = '{addr: fill_addr, len: BURST_LEN};
    assign ar_valid = state == BU_AR;
    assign r_ready  = state == BU_R;

    assign fill_wr_en = r_valid && r_ready;
    assign fill_wr    = '{way: cmd_q.way, index: addr_index(fill_addr), word_sel: beat,
                          data: r_data, strb: '1};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= BU_IDLE;
            cnt      <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                BU_IDLE: begin
                    if (cmd_valid) begin
                        cnt   <= '0;
                        state <= cmd.wb ? BU_BUFFER : BU_AR;
                    end
                end
                BU_BUFFER: begin
                    // ram read lags the address by one cycle
                    cnt <= cnt + 1'b1;
                    if (cnt == `DC_WORDS) begin
                        cnt   <= '0;
                        state <= BU_AW;
                    end
                end
                BU_AW: begin
                    if (aw_ready) begin
                        state <= BU_W;
                    end
                end
                BU_W: begin
                    if (w_ready) begin
                        cnt <= cnt + 1'b1;
                        if (w_last) begin
                            cnt   <= '0;
                            state <= BU_B;
                        end
                    end
                end
                BU_B: begin
                    if (b_valid) begin
                        state <= BU_AR;
                    end
                end
                BU_AR: begin
                    if (ar_ready) begin
                        state <= BU_R;
                    end
                end
                BU_R: begin
                    if (r_valid) begin
                        cnt <= cnt + 1'b1;
                        if (r_last) begin
                            cnt      <= '0;
                            cmd_done <= 1'b1;
                            state    <= BU_IDLE;
                        end
                    end
                end
                default: state <= BU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BU_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == BU_BUFFER && cnt != 0) begin
            line_buf[beat - 1'b1] <= line_data;
        end
    end

endmodule

//--- hdl/dcache_ctrl.sv
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  dcache_pkg::cpu_req_t            cpu_req,
    output logic                            done,
    output dcache_pkg::word_t               rdata,
    output dcache_pkg::index_t              lookup_index,
    output dcache_pkg::word_sel_t           lookup_word,
    input  dcache_pkg::tag_t [`DC_WAYS-1:0] tags,
    input  logic [`DC_WAYS-1:0]             valid,
    input  logic [`DC_WAYS-1:0]             dirty,
    input  logic [`DC_WAYS-1:0]             lru,
    input  dcache_pkg::word_t [`DC_WAYS-1:0] way_words,
    output logic                            flag_wr,
    output dcache_pkg::way_t                flag_way,
    output logic                            flag_dirty,
    output logic                            tag_wr,
    output dcache_pkg::fill_beat_t          hit_wr,
    output logic                            hit_wr_en,
    output logic                            cmd_valid,
    output dcache_pkg::burst_cmd_t          cmd,
    output dcache_pkg::addr_t               fill_addr,
    input  dcache_pkg::fill_beat_t          fill_beat,
    input  logic                            fill_beat_en,
    input  logic                            cmd_done
);
    import dcache_pkg::*;

    ctrl_state_e         state;
    cpu_req_t            q;
    logic [`DC_WAYS-1:0] hit_vec;
    logic                hit;
    way_t                hit_way;
    way_t                victim;
    logic                hit_q;
    way_t                way_q;
    logic                keep_dirty;
    word_t               rdata_q;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid[w] && tags[w] == addr_tag(q.addr);
        end
    end

    assign hit     = |hit_vec;
    assign hit_way = way_t'(hit_vec[1]);
    // way with its lru bit set goes first
    assign victim  = way_t'(lru[1]);

    // the stores are read with the incoming address while idle
    assign lookup_index = (state == IDLE) ? addr_index(cpu_req.addr) : addr_index(q.addr);
    assign lookup_word  = (state == IDLE) ? addr_word(cpu_req.addr) : addr_word(q.addr);

    assign fill_addr = line_addr(addr_tag(q.addr), addr_index(q.addr));
    assign cmd_valid = state == LOOKUP && !hit;

    always_comb begin
        cmd.wb   = valid[victim] && dirty[victim];
        cmd.way  = victim;
        cmd.addr = cmd.wb ? line_addr(tags[victim], addr_index(q.addr)) : fill_addr;
    end

    assign done  = state == RESPOND;
    assign rdata = rdata_q;

    // flags, tag and store data all land at the end of RESPOND
    assign flag_wr    = state == RESPOND;
    assign flag_way   = way_q;
    assign flag_dirty = q.we || keep_dirty;
    assign tag_wr     = state == RESPOND && !hit_q;

    // byte enables do the merge over the refilled word
    assign hit_wr_en = state == RESPOND && q.we;
    assign hit_wr    = '{way: way_q, index: addr_index(q.addr), word_sel: addr_word(q.addr),
                         data: q.wdata, strb: q.wstrb};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            hit_q      <= 1'b0;
            way_q      <= '0;
            keep_dirty <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    hit_q      <= hit;
                    way_q      <= hit ? hit_way : victim;
                    keep_dirty <= hit && dirty[hit_way];
                    if (hit) begin
                        state <= RESPOND;
                    end else if (cmd.wb) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= REFILL;
                    end
                end
                WRITEBACK: begin
                    // first refill beat means the old line is out
                    if (fill_beat_en) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (cmd_done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            q <= cpu_req;
        end
        if (state == LOOKUP) begin
            rdata_q <= way_words[hit_way];
        end
        if (fill_beat_en && fill_beat.word_sel == addr_word(q.addr)) begin
            rdata_q <= fill_beat.data;
        end
    end

endmodule

//--- hdl/dcache_data_store.sv
`include "dcache_macros.svh"

module dcache_data_store (
    input  logic                             clk,
    input  dcache_pkg::index_t               lookup_index,
    input  dcache_pkg::word_sel_t            lookup_word,
    output dcache_pkg::word_t [`DC_WAYS-1:0] way_words,
    input  dcache_pkg::index_t               line_index,
    input  dcache_pkg::way_t                 line_way,
    input  dcache_pkg::word_sel_t            line_word,
    output dcache_pkg::word_t                line_data,
    input  dcache_pkg::fill_beat_t           hit_wr,
    input  logic                             hit_wr_en,
    input  dcache_pkg::fill_beat_t           fill_wr,
    input  logic                             fill_wr_en
);
    import dcache_pkg::*;

    localparam int DEPTH = (1 << `DC_INDEX_BITS) * `DC_WORDS;

    fill_beat_t                wr;
    logic                      wr_en;
    word_t [`DC_WAYS-1:0]      line_rd;
    way_t                      line_way_q;

    // controller and burst unit never write in the same cycle
    assign wr    = hit_wr_en ? hit_wr : fill_wr;
    assign wr_en = hit_wr_en | fill_wr_en;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic [$bits(strb_t)-1:0][7:0] ram [DEPTH];
        word_t look_q;
        word_t line_q;

        always_ff @(posedge clk) begin
            if (wr_en && wr.way == way_t'(w)) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (wr.strb[b]) begin
                        ram[{wr.index, wr.word_sel}][b] <= wr.data[8*b +: 8];
                    end
                end
            end
            look_q <= ram[{lookup_index, lookup_word}];
            line_q <= ram[{line_index, line_word}];
        end

        assign way_words[w] = look_q;
        assign line_rd[w]   = line_q;
    end

    always_ff @(posedge clk) begin
        line_way_q <= line_way;
    end

    assign line_data = line_rd[line_way_q];

endmodule

//--- hdl/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// byte address width of the core
`define DC_ADDR_W 32

// byte offset inside a 32-byte line
`define DC_OFFSET_BITS 5

// 128 sets
`define DC_INDEX_BITS 7

// what is left of the address above index and offset
`define DC_TAG_BITS 20

// words per line, also beats per burst
`define DC_WORDS 8

`define DC_WAYS 2

// burst len field value
`define DC_BURST_LEN (`DC_WORDS - 1)

`endif

//--- hdl/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]          addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [3:0]                     strb_t;
    typedef logic [`DC_TAG_BITS-1:0]        tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]      index_t;
    typedef logic [$clog2(`DC_WORDS)-1:0]   word_sel_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]    way_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  we;
    } cpu_req_t;

    // addr is the victim line for a write-back, else the refill line
    typedef struct packed {
        logic  wb;
        addr_t addr;
        way_t  way;
    } burst_cmd_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } axi_addr_t;

    typedef struct packed {
        way_t      way;
        index_t    index;
        word_sel_t word_sel;
        word_t     data;
        strb_t     strb;
    } fill_beat_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[`DC_ADDR_W-1 -: `DC_TAG_BITS];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    endfunction

    function automatic word_sel_t addr_word(addr_t a);
        return a[`DC_OFFSET_BITS-1 -: $bits(word_sel_t)];
    endfunction

    function automatic addr_t line_addr(tag_t t, index_t i);
        return {t, i, {`DC_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

//--- hdl/dcache_tag_store.sv
`include "dcache_macros.svh"

module dcache_tag_store (
    input  logic                            clk,
    input  logic                            rst,
    input  dcache_pkg::index_t              index,
    output dcache_pkg::tag_t [`DC_WAYS-1:0] tags,
    output logic [`DC_WAYS-1:0]             valid,
    output logic [`DC_WAYS-1:0]             dirty,
    output logic [`DC_WAYS-1:0]             lru,
    input  logic                            flag_wr,
    input  dcache_pkg::way_t                flag_way,
    input  logic                            flag_dirty,
    input  logic                            tag_wr,
    input  dcache_pkg::tag_t                new_tag
);
    import dcache_pkg::*;

    localparam int SETS = 1 << `DC_INDEX_BITS;

    logic [`DC_WAYS-1:0] valid_q [SETS];
    logic [`DC_WAYS-1:0] dirty_q [SETS];
    logic [`DC_WAYS-1:0] lru_q   [SETS];

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        tag_t ram [SETS];
        tag_t rd_q;

        always_ff @(posedge clk) begin
            if (tag_wr && flag_way == way_t'(w)) begin
                ram[index] <= new_tag;
            end
            rd_q <= ram[index];
        end

        assign tags[w] = rd_q;
    end

    // flags live in flops so reset can clear every set at once
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            lru_q   <= '{default: '0};
            valid   <= '0;
            dirty   <= '0;
            lru     <= '0;
        end else begin
            if (flag_wr) begin
                valid_q[index][flag_way] <= 1'b1;
                dirty_q[index][flag_way] <= flag_dirty;
                // touched way becomes MRU, the other one is next victim
                lru_q[index] <= ~(`DC_WAYS'(1) << flag_way);
            end
            valid <= valid_q[index];
            dirty <= dirty_q[index];
            lru   <= lru_q[index];
        end
    end

endmodule

//--- hdl/dcache_top.sv
`include "dcache_macros.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  done,
    output dcache_pkg::word_t     rdata,
    output dcache_pkg::axi_addr_t ar,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    input  dcache_pkg::word_t     r_data,
    input  logic                  r_last,
    input  logic                  r_valid,
    output logic                  r_ready,
    output dcache_pkg::axi_addr_t aw,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output dcache_pkg::word_t     w_data,
    output logic                  w_last,
    output logic                  w_valid,
    input  logic                  w_ready,
    input  logic                  b_valid
);
    import dcache_pkg::*;

    index_t                lookup_index;
    word_sel_t             lookup_word;
    tag_t [`DC_WAYS-1:0]   tags;
    logic [`DC_WAYS-1:0]   valid;
    logic [`DC_WAYS-1:0]   dirty;
    logic [`DC_WAYS-1:0]   lru;
    word_t [`DC_WAYS-1:0]  way_words;
    logic                  flag_wr;
    way_t                  flag_way;
    logic                  flag_dirty;
    logic                  tag_wr;
    fill_beat_t            hit_wr;
    logic                  hit_wr_en;
    logic                  cmd_valid;
    burst_cmd_t            cmd;
    addr_t                 fill_addr;
    fill_beat_t            fill_wr;
    logic                  fill_wr_en;
    logic                  cmd_done;
    index_t                line_index;
    way_t                  line_way;
    word_sel_t             line_word;
    word_t                 line_data;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req, .cpu_req, .done, .rdata,
        .lookup_index, .lookup_word,
        .tags, .valid, .dirty, .lru, .way_words,
        .flag_wr, .flag_way, .flag_dirty, .tag_wr,
        .hit_wr, .hit_wr_en,
        .cmd_valid, .cmd, .fill_addr,
        .fill_beat(fill_wr), .fill_beat_en(fill_wr_en), .cmd_done
    );

    // the refill line address carries the tag to install
    dcache_tag_store u_tag_store (
        .clk, .rst, .index(lookup_index),
        .tags, .valid, .dirty, .lru,
        .flag_wr, .flag_way, .flag_dirty, .tag_wr,
        .new_tag(addr_tag(fill_addr))
    );

    dcache_data_store u_data_store (
        .clk, .lookup_index, .lookup_word, .way_words,
        .line_index, .line_way, .line_word, .line_data,
        .hit_wr, .hit_wr_en, .fill_wr, .fill_wr_en
    );

    dcache_burst_unit u_burst_unit (
        .clk, .rst, .cmd_valid, .cmd, .fill_addr, .cmd_done,
        .line_index, .line_way, .line_word, .line_data,
        .fill_wr, .fill_wr_en,
        .ar, .ar_valid, .ar_ready,
        .r_data, .r_last, .r_valid, .r_ready,
        .aw, .aw_valid, .aw_ready,
        .w_data, .w_last, .w_valid, .w_ready,
        .b_valid
    );

endmodule
